//--- hdl/vmsu_pkg.sv
// Shared widths and stage types for the pipelined signed/unsigned Vedic multiplier

package vmsu_pkg;

    // Operand and product widths
    localparam int OPERAND_W = 8;
    localparam int HALF_W    = OPERAND_W / 2;
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // Sign view of an input byte
    typedef struct packed {
        logic                 sign;
        logic [OPERAND_W-2:0] low;
    } operand_fields_t;

    // One input byte, read as an unsigned value or as sign plus low bits
    typedef union packed {
        logic [OPERAND_W-1:0] raw;
        operand_fields_t      fields;
    } operand_t;

    // Decode to execute
    typedef struct packed {
        logic [OPERAND_W-1:0] mag_a;
        logic [OPERAND_W-1:0] mag_b;
        logic                 neg_a;
        logic                 neg_b;
    } decoded_t;

    // Execute to result with the product still unsigned
    typedef struct packed {
        logic [PRODUCT_W-1:0] product;
        logic                 neg_a;
        logic                 neg_b;
    } executed_t;

endpackage

//--- hdl/cla_adder.sv
// Carry-lookahead adder of configurable width

`timescale 1ns/1ps

module cla_adder #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0] x,
    input  logic [WIDTH-1:0] y,
    input  logic             cin,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    logic [WIDTH-1:0] prop;
    logic [WIDTH-1:0] gen;
    logic [WIDTH:0]   carry;

    assign prop = x ^ y;
    assign gen  = x & y;

    // Every carry is a flat sum of products over the lower bits and cin
    always_comb begin
        logic chain;
        carry[0] = cin;
        for (int i = 0; i < WIDTH; i++) begin
            carry[i+1] = gen[i];
            chain      = prop[i];
            for (int j = i - 1; j >= 0; j--) begin
                carry[i+1] = carry[i+1] | (chain & gen[j]);
                chain      = chain & prop[j];
            end
            carry[i+1] = carry[i+1] | (chain & cin);
        end
    end

    assign sum  = prop ^ carry[WIDTH-1:0];
    assign cout = carry[WIDTH];

endmodule

//--- hdl/vedic_mult_4x4.sv
// Combinational 4x4 Vedic multiplier from four 2x2 crosswise products

`timescale 1ns/1ps

module vedic_mult_4x4 (
    input  logic [vmsu_pkg::HALF_W-1:0]   x,
    input  logic [vmsu_pkg::HALF_W-1:0]   y,
    output logic [2*vmsu_pkg::HALF_W-1:0] prod
);
    import vmsu_pkg::*;

    logic [HALF_W-1:0] pp_ll;
    logic [HALF_W-1:0] pp_lh;
    logic [HALF_W-1:0] pp_hl;
    logic [HALF_W-1:0] pp_hh;
    logic [HALF_W-1:0] cross_sum;
    logic [HALF_W-1:0] mid_sum;
    logic [HALF_W-1:0] hi_sum;
    logic              cross_carry;
    logic              mid_carry;
    logic              carry_or;

    // 2x2 block from AND terms and two half adders
    function automatic logic [3:0] mult_2x2(input logic [1:0] u, input logic [1:0] v);
        logic [3:0] r;
        logic       t01;
        logic       t10;
        logic       t11;
        logic       c_mid;
        r[0]  = u[0] & v[0];
        t01   = u[0] & v[1];
        t10   = u[1] & v[0];
        t11   = u[1] & v[1];
        r[1]  = t01 ^ t10;
        c_mid = t01 & t10;
        r[2]  = t11 ^ c_mid;
        r[3]  = t11 & c_mid;
        return r;
    endfunction

    assign pp_ll = mult_2x2(x[HALF_W/2-1:0],      y[HALF_W/2-1:0]);
    assign pp_lh = mult_2x2(x[HALF_W/2-1:0],      y[HALF_W-1:HALF_W/2]);
    assign pp_hl = mult_2x2(x[HALF_W-1:HALF_W/2], y[HALF_W/2-1:0]);
    assign pp_hh = mult_2x2(x[HALF_W-1:HALF_W/2], y[HALF_W-1:HALF_W/2]);

    // Crosswise terms
    cla_adder #(.WIDTH(HALF_W)) u_add_cross (
        .x    (pp_lh),
        .y    (pp_hl),
        .cin  (1'b0),
        .sum  (cross_sum),
        .cout (cross_carry)
    );

    // Fold in the upper half of the low product
    cla_adder #(.WIDTH(HALF_W)) u_add_mid (
        .x    (cross_sum),
        .y    ({{(HALF_W/2){1'b0}}, pp_ll[HALF_W-1:HALF_W/2]}),
        .cin  (1'b0),
        .sum  (mid_sum),
        .cout (mid_carry)
    );

    assign carry_or = cross_carry | mid_carry;

    // Product fits in 2*HALF_W bits, so the last carry is always zero
    cla_adder #(.WIDTH(HALF_W)) u_add_hi (
        .x    (pp_hh),
        .y    ({{(HALF_W/2-1){1'b0}}, carry_or, mid_sum[HALF_W-1:HALF_W/2]}),
        .cin  (1'b0),
        .sum  (hi_sum),
        .cout ()
    );

    assign prod = {hi_sum, mid_sum[HALF_W/2-1:0], pp_ll[HALF_W/2-1:0]};

endmodule

//--- hdl/operand_decode.sv
// Decode stage that registers the operands, detects negative inputs and forms magnitudes

`timescale 1ns/1ps

module operand_decode (
    input  logic               clk,
    input  logic               rst,
    input  vmsu_pkg::operand_t a,
    input  vmsu_pkg::operand_t b,
    input  logic               control,
    output vmsu_pkg::decoded_t decoded
);
    import vmsu_pkg::*;

    operand_t             a_q;
    operand_t             b_q;
    logic                 control_q;
    logic                 neg_a;
    logic                 neg_b;
    logic [OPERAND_W-1:0] mag_a;
    logic [OPERAND_W-1:0] mag_b;

    // Input register
    always_ff @(posedge clk) begin
        if (rst) begin
            a_q       <= '0;
            b_q       <= '0;
            control_q <= 1'b0;
        end else begin
            a_q       <= a;
            b_q       <= b;
            control_q <= control;
        end
    end

    // Sign bit only counts in two's complement mode
    assign neg_a = control_q & a_q.fields.sign;
    assign neg_b = control_q & b_q.fields.sign;

    // Negative operands are replaced by their magnitude
    assign mag_a = neg_a ? ~a_q.raw + 1'b1 : a_q.raw;
    assign mag_b = neg_b ? ~b_q.raw + 1'b1 : b_q.raw;

    always_ff @(posedge clk) begin
        if (rst) begin
            decoded <= '0;
        end else begin
            decoded.mag_a <= mag_a;
            decoded.mag_b <= mag_b;
            decoded.neg_a <= neg_a;
            decoded.neg_b <= neg_b;
        end
    end

endmodule

//--- hdl/vedic_execute.sv
// Execute stage that registers the 8x8 Vedic product of the magnitudes with the sign flags

`timescale 1ns/1ps

module vedic_execute (
    input  logic                clk,
    input  logic                rst,
    input  vmsu_pkg::decoded_t  decoded,
    output vmsu_pkg::executed_t executed
);
    import vmsu_pkg::*;

    logic [OPERAND_W-1:0] pp_ll;
    logic [OPERAND_W-1:0] pp_lh;
    logic [OPERAND_W-1:0] pp_hl;
    logic [OPERAND_W-1:0] pp_hh;
    logic [OPERAND_W-1:0] cross_sum;
    logic [OPERAND_W-1:0] mid_sum;
    logic [OPERAND_W-1:0] hi_sum;
    logic                 cross_carry;
    logic                 mid_carry;
    logic                 carry_or;
    logic [PRODUCT_W-1:0] product;

    vedic_mult_4x4 u_mult_ll (
        .x(decoded.mag_a[HALF_W-1:0]), .y(decoded.mag_b[HALF_W-1:0]), .prod(pp_ll)
    );
    vedic_mult_4x4 u_mult_lh (
        .x(decoded.mag_a[HALF_W-1:0]), .y(decoded.mag_b[OPERAND_W-1:HALF_W]), .prod(pp_lh)
    );
    vedic_mult_4x4 u_mult_hl (
        .x(decoded.mag_a[OPERAND_W-1:HALF_W]), .y(decoded.mag_b[HALF_W-1:0]), .prod(pp_hl)
    );
    vedic_mult_4x4 u_mult_hh (
        .x(decoded.mag_a[OPERAND_W-1:HALF_W]), .y(decoded.mag_b[OPERAND_W-1:HALF_W]),
        .prod(pp_hh)
    );

    // Same crosswise merge as inside the 4x4 block, one level up
    cla_adder #(.WIDTH(OPERAND_W)) u_add_cross (
        .x(pp_lh), .y(pp_hl), .cin(1'b0), .sum(cross_sum), .cout(cross_carry)
    );
    cla_adder #(.WIDTH(OPERAND_W)) u_add_mid (
        .x    (cross_sum),
        .y    ({{HALF_W{1'b0}}, pp_ll[OPERAND_W-1:HALF_W]}),
        .cin  (1'b0),
        .sum  (mid_sum),
        .cout (mid_carry)
    );

    assign carry_or = cross_carry | mid_carry;

    cla_adder #(.WIDTH(OPERAND_W)) u_add_hi (
        .x    (pp_hh),
        .y    ({{(HALF_W-1){1'b0}}, carry_or, mid_sum[OPERAND_W-1:HALF_W]}),
        .cin  (1'b0),
        .sum  (hi_sum),
        .cout ()
    );

    assign product = {hi_sum, mid_sum[HALF_W-1:0], pp_ll[HALF_W-1:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            executed <= '0;
        end else begin
            executed.product <= product;
            executed.neg_a   <= decoded.neg_a;
            executed.neg_b   <= decoded.neg_b;
        end
    end

endmodule

//--- hdl/sign_restore.sv
// Result stage that negates the product for mixed-sign operands and registers the output

`timescale 1ns/1ps

module sign_restore (
    input  logic                            clk,
    input  logic                            rst,
    input  vmsu_pkg::executed_t             executed,
    output logic [vmsu_pkg::PRODUCT_W-1:0]  p
);
    import vmsu_pkg::*;

    logic                 negate;
    logic [PRODUCT_W-1:0] p_next;

    // Exactly one negative operand gives a negative result
    assign negate = executed.neg_a ^ executed.neg_b;

    assign p_next = negate ? ~executed.product + 1'b1 : executed.product;

    // Output register
    always_ff @(posedge clk) begin
        if (rst) begin
            p <= '0;
        end else begin
            p <= p_next;
        end
    end

endmodule

//--- hdl/vmsu_top.sv
// Top level of the four-stage pipelined signed/unsigned Vedic multiplier

`timescale 1ns/1ps

module vmsu_top (
    input  logic                           clk,
    input  logic                           rst,
    input  vmsu_pkg::operand_t             a,
    input  vmsu_pkg::operand_t             b,
    input  logic                           control,
    output logic [vmsu_pkg::PRODUCT_W-1:0] p
);
    import vmsu_pkg::*;

    decoded_t  decoded;
    executed_t executed;

    // Input and magnitude registers
    operand_decode u_decode (
        .clk     (clk),
        .rst     (rst),
        .a       (a),
        .b       (b),
        .control (control),
        .decoded (decoded)
    );

    // Multiplier tree register
    vedic_execute u_execute (
        .clk      (clk),
        .rst      (rst),
        .decoded  (decoded),
        .executed (executed)
    );

    // Output register
    sign_restore u_restore (
        .clk      (clk),
        .rst      (rst),
        .executed (executed),
        .p        (p)
    );

endmodule

//--- dv/tb_vmsu.sv
// Testbench for the pipelined Vedic multiplier with random and directed operands

`timescale 1ns/1ps

module tb_vmsu;
    import vmsu_pkg::*;

    localparam int LATENCY     = 4;
    localparam int DRAIN_LIMIT = 20;

    // One sampled operand set and the product it should give
    typedef struct packed {
        logic [OPERAND_W-1:0] op_a;
        logic [OPERAND_W-1:0] op_b;
        logic                 control;
        logic [PRODUCT_W-1:0] expected;
    } entry_t;

    logic                 clk;
    logic                 rst;
    operand_t             a;
    operand_t             b;
    logic                 control;
    logic [PRODUCT_W-1:0] p;

    entry_t pipe_q[$];
    int     push_count;
    int     pop_count;
    int     mismatches;
    int     timeouts;

    vmsu_top UUT (
        .clk     (clk),
        .rst     (rst),
        .a       (a),
        .b       (b),
        .control (control),
        .p       (p)
    );

    always #20 clk = ~clk;

    // Reference model giving the low 16 bits of the unsigned or two's complement product
    function automatic logic [PRODUCT_W-1:0] expected_product(
        input logic [OPERAND_W-1:0] op_a,
        input logic [OPERAND_W-1:0] op_b,
        input logic                 ctrl
    );
        int sa;
        int sb;
        int full;
        if (ctrl) begin
            sa = $signed(op_a);
            sb = $signed(op_b);
        end else begin
            sa = op_a;
            sb = op_b;
        end
        full = sa * sb;
        return full[PRODUCT_W-1:0];
    endfunction

    // Record what the next edge samples and check what the last edge produced
    always @(negedge clk) begin
        entry_t head;
        entry_t cur;
        entry_t tmp;
        if (pipe_q.size() >= LATENCY) begin
            head = pipe_q.pop_front();
            pop_count++;
            if (p !== head.expected) begin
                mismatches++;
                $display("Mismatch at %0t ns: a=%02h b=%02h control=%0b expected %04h, got %04h",
                         $time, head.op_a, head.op_b, head.control, head.expected, p);
            end
        end
        cur.op_a     = a.raw;
        cur.op_b     = b.raw;
        cur.control  = control;
        cur.expected = expected_product(a.raw, b.raw, control);
        // Reset empties every stage, so all products in flight read zero
        if (rst) begin
            cur.expected = '0;
            for (int i = 0; i < pipe_q.size(); i++) begin
                tmp          = pipe_q[i];
                tmp.expected = '0;
                pipe_q[i]    = tmp;
            end
        end
        pipe_q.push_back(cur);
        push_count++;
    end

    task automatic drive_operands(
        input logic [OPERAND_W-1:0] op_a,
        input logic [OPERAND_W-1:0] op_b,
        input logic                 ctrl
    );
        @(posedge clk);
        #2;
        a.raw   = op_a;
        b.raw   = op_b;
        control = ctrl;
    endtask

    task automatic drive_random(input int count, input logic fixed_mode, input logic ctrl);
        logic mode;
        for (int i = 0; i < count; i++) begin
            mode = fixed_mode ? ctrl : logic'($urandom() & 1);
            drive_operands(OPERAND_W'($urandom()), OPERAND_W'($urandom()), mode);
        end
    endtask

    // Called right after a drive, so rst lines up with the sampling edges
    task automatic apply_reset(input int cycles);
        rst = 1'b1;
        repeat (cycles) @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    task automatic wait_for_drain();
        int target;
        int cycles;
        @(posedge clk);
        target = push_count + LATENCY;
        cycles = 0;
        while (pop_count < target && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (pop_count < target) begin
            timeouts++;
            $display("Timed out after %0d cycles waiting for the last products to leave",
                     cycles);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        a          = '0;
        b          = '0;
        control    = 1'b0;
        push_count = 0;
        pop_count  = 0;
        mismatches = 0;
        timeouts   = 0;
        void'($urandom(32'hf0078fcb));

        // Stages are empty before the first edge
        repeat (LATENCY) pipe_q.push_back('0);

        apply_reset(2);

        // Unsigned corners
        drive_operands(8'hff, 8'hff, 1'b0);
        drive_operands(8'h00, 8'hc3, 1'b0);
        drive_operands(8'h5a, 8'h00, 1'b0);
        drive_operands(8'h01, 8'he7, 1'b0);
        drive_operands(8'h9d, 8'h01, 1'b0);
        drive_operands(8'h80, 8'h80, 1'b0);
        drive_random(40, 1'b1, 1'b0);

        // Signed corners
        drive_operands(8'h80, 8'h80, 1'b1);
        drive_operands(8'h80, 8'h7f, 1'b1);
        drive_operands(8'hff, 8'hff, 1'b1);
        drive_operands(8'hff, 8'h01, 1'b1);
        drive_operands(8'h00, 8'h80, 1'b1);
        drive_operands(8'h7f, 8'h7f, 1'b1);
        drive_random(40, 1'b1, 1'b1);

        // Mixed modes back to back
        drive_random(60, 1'b0, 1'b0);

        // Reset in the middle of a stream
        drive_random(10, 1'b0, 1'b0);
        apply_reset(1);
        drive_random(12, 1'b0, 1'b0);

        wait_for_drain();

        $display("Checks: %0d, mismatches: %0d, timeouts: %0d",
                 pop_count, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
hdl/vmsu_pkg.sv
hdl/cla_adder.sv
hdl/vedic_mult_4x4.sv
hdl/operand_decode.sv
hdl/vedic_execute.sv
hdl/sign_restore.sv
hdl/vmsu_top.sv
dv/tb_vmsu.sv

//--- Bender.yml
package:
  name: vmsu

sources:
  - hdl/vmsu_pkg.sv
  - hdl/cla_adder.sv
  - hdl/vedic_mult_4x4.sv
  - hdl/operand_decode.sv
  - hdl/vedic_execute.sv
  - hdl/sign_restore.sv
  - hdl/vmsu_top.sv
  - target: test
    files:
      - dv/tb_vmsu.sv
